//--- logic/dma_byte_fifo.sv
`timescale 1ns/10ps

module dma_byte_fifo (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         push,
    input  logic [1:0]                   push_size,
    input  logic [31:0]                  push_data,
    input  logic                         pop,
    input  logic [1:0]                   pop_size,
    output logic [31:0]                  pop_data,
    output logic                         full,
    output logic [dma_pkg::FIFO_DEPTH_LOG:0] level
);
    import dma_pkg::*;

    logic [7:0]                mem [FIFO_SIZE];
    logic [FIFO_DEPTH_LOG-1:0] wptr;
    logic [FIFO_DEPTH_LOG-1:0] rptr;
    logic [FIFO_DEPTH_LOG:0]   push_n;
    logic [FIFO_DEPTH_LOG:0]   pop_n;

    // byte counts moved this cycle
    assign push_n = push ? {{(FIFO_DEPTH_LOG-1){1'b0}}, push_size} +
                           {{FIFO_DEPTH_LOG{1'b0}}, 1'b1} : '0;
    assign pop_n  = pop  ? {{(FIFO_DEPTH_LOG-1){1'b0}}, pop_size} +
                           {{FIFO_DEPTH_LOG{1'b0}}, 1'b1} : '0;

    assign full = level >= (FIFO_DEPTH_LOG+1)'(FIFO_HALF);

    always_ff @(posedge clk) begin
        if (push) begin
            for (int i = 0; i < 4; i++) begin
                if (i <= int'(push_size))
                    mem[wptr + FIFO_DEPTH_LOG'(i)] <= push_data[8*i +: 8];
            end
        end
    end

    // little-endian, unread lanes zero
    always_comb begin
        pop_data = '0;
        for (int i = 0; i < 4; i++) begin
            if (i <= int'(pop_size))
                pop_data[8*i +: 8] = mem[rptr + FIFO_DEPTH_LOG'(i)];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (~rstn) begin
            wptr  <= '0;
            rptr  <= '0;
            level <= '0;
        end else begin
            wptr  <= wptr + push_n[FIFO_DEPTH_LOG-1:0];
            rptr  <= rptr + pop_n[FIFO_DEPTH_LOG-1:0];
            level <= level + push_n - pop_n;
        end
    end

endmodule

//--- logic/dma_pkg.sv
package dma_pkg;

    localparam int ADDR_W = 32;

    // register map, decoded from paddr[7:0]
    localparam logic [7:0] REG_SRC  = 8'h00;
    localparam logic [7:0] REG_DEST = 8'h04;
    localparam logic [7:0] REG_LEN  = 8'h08;
    localparam logic [7:0] REG_CON  = 8'h0C;

    // addressing types, code 2 is reserved
    localparam logic [1:0] TYPE_FIXED = 2'd0;
    localparam logic [1:0] TYPE_INCR  = 2'd1;
    localparam logic [1:0] TYPE_RSVD  = 2'd2;
    localparam logic [1:0] TYPE_CONST = 2'd3;

    // access sizes, code 3 is rejected
    localparam logic [1:0] SIZE_BYTE  = 2'd0;
    localparam logic [1:0] SIZE_HWORD = 2'd1;
    localparam logic [1:0] SIZE_WORD  = 2'd2;

    localparam int FIFO_DEPTH_LOG = 6;
    localparam int FIFO_SIZE      = 1 << FIFO_DEPTH_LOG;
    localparam int FIFO_HALF      = FIFO_SIZE / 2;

    typedef struct packed {
        logic        busy;
        logic [18:0] rsv_hi;
        logic [1:0]  dest_size;
        logic [1:0]  src_size;
        logic [1:0]  dest_type;
        logic [1:0]  src_type;
        logic [2:0]  rsv_lo;
        logic        en;
    } dma_con_s;

    typedef union packed {
        logic [31:0] w;
        dma_con_s    f;
    } dma_con_u;

    // bytes per beat minus one, also the low address mask
    function automatic logic [1:0] size_m1(input logic [1:0] size);
        return {size == SIZE_WORD, size != SIZE_BYTE};
    endfunction

endpackage

//--- logic/dma_rd_engine.sv
`timescale 1ns/10ps

module dma_rd_engine (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       start,
    input  logic [dma_pkg::ADDR_W-1:0] cfg_src,
    input  logic [dma_pkg::ADDR_W-1:0] cfg_len,
    input  logic [1:0]                 src_type,
    input  logic [1:0]                 src_size,
    input  logic                       full,
    input  logic                       arready,
    input  logic [31:0]                rdata,
    input  logic                       rvalid,
    output logic [dma_pkg::ADDR_W-1:0] araddr,
    output logic [2:0]                 arsize,
    output logic                       arvalid,
    output logic                       rready,
    output logic                       push,
    output logic [1:0]                 push_size,
    output logic [31:0]                push_data,
    output logic                       rd_done
);
    import dma_pkg::*;

    logic [ADDR_W-1:0] addr;
    logic [ADDR_W-1:0] cnt;
    logic [ADDR_W-1:0] step;
    logic              is_const;
    logic              last;
    logic              ar_want;

    assign is_const  = src_type == TYPE_CONST;
    assign push_size = size_m1(src_size);
    assign step      = ADDR_W'(push_size) + ADDR_W'(1);
    assign last      = cnt == step;

    assign araddr = addr;
    assign arsize = {1'b0, src_size};
    assign rready = 1'b1;
    // full cannot rise while a read is pending, so arvalid holds once raised
    assign arvalid = ar_want && ~full;

    // const source pushes the pattern held in addr
    assign push      = is_const ? (|cnt && ~full) : (rvalid && rready && |cnt);
    assign push_data = is_const ? addr : (rdata >> {addr[1:0], 3'b0});

    always_ff @(posedge clk or negedge rstn) begin
        if (~rstn) begin
            addr    <= '0;
            cnt     <= '0;
            ar_want <= 1'b0;
            rd_done <= 1'b0;
        end else if (start) begin
            addr    <= cfg_src;
            cnt     <= cfg_len;
            ar_want <= ~is_const;
            rd_done <= 1'b0;
        end else if (arvalid && arready) begin
            ar_want <= 1'b0;
        end else if (push) begin
            cnt <= cnt - step;
            if (src_type == TYPE_INCR)
                addr <= addr + step;
            if (~is_const)
                ar_want <= ~last;
            if (last)
                rd_done <= 1'b1;
        end
    end

endmodule

//--- logic/dma_regs.sv
`timescale 1ns/10ps

module dma_regs (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [dma_pkg::ADDR_W-1:0] paddr,
    input  logic [dma_pkg::ADDR_W-1:0] pwdata,
    input  logic                       wr_done,
    output logic [dma_pkg::ADDR_W-1:0] prdata,
    output logic                       pready,
    output logic                       pslverr,
    output logic                       start,
    output logic [dma_pkg::ADDR_W-1:0] cfg_src,
    output logic [dma_pkg::ADDR_W-1:0] cfg_dest,
    output logic [dma_pkg::ADDR_W-1:0] cfg_len,
    output logic [1:0]                 src_type,
    output logic [1:0]                 dest_type,
    output logic [1:0]                 src_size,
    output logic [1:0]                 dest_size
);
    import dma_pkg::*;

    logic              apb_setup;
    logic              apb_wr;
    logic              bad_code;
    logic              src_mis;
    logic              dest_mis;
    logic              len_mis;
    logic              cfg_err;
    dma_con_u          con_q;
    dma_con_u          con_wr;
    logic [ADDR_W-1:0] rd_mux;

    assign apb_setup = psel && ~penable;
    assign apb_wr    = apb_setup && pwrite;
    assign con_wr.w  = pwdata;

    assign pready  = 1'b1;
    assign pslverr = 1'b0;

    assign src_type  = con_q.f.src_type;
    assign dest_type = con_q.f.dest_type;
    assign src_size  = con_q.f.src_size;
    assign dest_size = con_q.f.dest_size;

    // destination is memory only
    assign bad_code = src_type == TYPE_RSVD || dest_type == TYPE_RSVD ||
                      dest_type == TYPE_CONST ||
                      src_size > SIZE_WORD || dest_size > SIZE_WORD;
    assign src_mis  = (src_type == TYPE_FIXED || src_type == TYPE_INCR) &&
                      |(cfg_src[1:0] & size_m1(src_size));
    assign dest_mis = |(cfg_dest[1:0] & size_m1(dest_size));
    assign len_mis  = |(cfg_len[1:0] & (size_m1(src_size) | size_m1(dest_size)));
    assign cfg_err  = ~|cfg_len || bad_code || src_mis || dest_mis || len_mis;

    // checked the cycle after the control write
    assign start = con_q.f.en && ~cfg_err;

    always_ff @(posedge clk or negedge rstn) begin
        if (~rstn) begin
            cfg_src  <= '0;
            cfg_dest <= '0;
            cfg_len  <= '0;
        end else if (apb_wr) begin
            if (paddr[7:0] == REG_SRC)
                cfg_src <= pwdata;
            if (paddr[7:0] == REG_DEST)
                cfg_dest <= pwdata;
            if (paddr[7:0] == REG_LEN)
                cfg_len <= pwdata;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (~rstn) begin
            con_q.w <= '0;
        end else if (apb_wr && paddr[7:0] == REG_CON && ~con_q.f.busy) begin
            con_q.f.en        <= con_wr.f.en;
            con_q.f.busy      <= con_wr.f.en;
            con_q.f.src_type  <= con_wr.f.src_type;
            con_q.f.dest_type <= con_wr.f.dest_type;
            con_q.f.src_size  <= con_wr.f.src_size;
            con_q.f.dest_size <= con_wr.f.dest_size;
        end else begin
            con_q.f.en <= 1'b0;
            if ((con_q.f.en && cfg_err) || wr_done)
                con_q.f.busy <= 1'b0;
        end
    end

    always_comb begin
        case (paddr[7:0])
            REG_SRC:  rd_mux = cfg_src;
            REG_DEST: rd_mux = cfg_dest;
            REG_LEN:  rd_mux = cfg_len;
            REG_CON:  rd_mux = con_q.w;
            default:  rd_mux = '0;
        endcase
    end

    // sampled in setup, valid in access phase
    always_ff @(posedge clk or negedge rstn) begin
        if (~rstn)
            prdata <= '0;
        else if (apb_setup)
            prdata <= rd_mux;
    end

endmodule

//--- logic/dma_top.sv
`timescale 1ns/10ps

module dma_top (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [dma_pkg::ADDR_W-1:0] paddr,
    input  logic [dma_pkg::ADDR_W-1:0] pwdata,
    output logic [dma_pkg::ADDR_W-1:0] prdata,
    output logic                       pready,
    output logic                       pslverr,
    output logic [dma_pkg::ADDR_W-1:0] araddr,
    output logic [2:0]                 arsize,
    output logic                       arvalid,
    input  logic                       arready,
    input  logic [31:0]                rdata,
    input  logic                       rvalid,
    output logic                       rready,
    output logic [dma_pkg::ADDR_W-1:0] awaddr,
    output logic [2:0]                 awsize,
    output logic                       awvalid,
    input  logic                       awready,
    output logic [31:0]                wdata,
    output logic [3:0]                 wstrb,
    output logic                       wvalid,
    input  logic                       wready,
    input  logic                       bvalid,
    output logic                       bready
);
    import dma_pkg::*;

    logic                    start;
    logic [ADDR_W-1:0]       cfg_src;
    logic [ADDR_W-1:0]       cfg_dest;
    logic [ADDR_W-1:0]       cfg_len;
    logic [1:0]              src_type;
    logic [1:0]              dest_type;
    logic [1:0]              src_size;
    logic [1:0]              dest_size;
    logic                    push;
    logic [1:0]              push_size;
    logic [31:0]             push_data;
    logic                    pop;
    logic [1:0]              pop_size;
    logic [31:0]             pop_data;
    logic                    full;
    logic [FIFO_DEPTH_LOG:0] level;
    logic                    rd_done;
    logic                    wr_done;
    logic                    xfer_done;

    // all read and all written
    assign xfer_done = rd_done && wr_done;

    dma_regs u_regs (
        .clk(clk), .rstn(rstn),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .wr_done(xfer_done),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .start(start), .cfg_src(cfg_src), .cfg_dest(cfg_dest), .cfg_len(cfg_len),
        .src_type(src_type), .dest_type(dest_type),
        .src_size(src_size), .dest_size(dest_size)
    );

    dma_byte_fifo u_fifo (
        .clk(clk), .rstn(rstn),
        .push(push), .push_size(push_size), .push_data(push_data),
        .pop(pop), .pop_size(pop_size), .pop_data(pop_data),
        .full(full), .level(level)
    );

    dma_rd_engine u_rd (
        .clk(clk), .rstn(rstn), .start(start),
        .cfg_src(cfg_src), .cfg_len(cfg_len),
        .src_type(src_type), .src_size(src_size), .full(full),
        .arready(arready), .rdata(rdata), .rvalid(rvalid),
        .araddr(araddr), .arsize(arsize), .arvalid(arvalid), .rready(rready),
        .push(push), .push_size(push_size), .push_data(push_data),
        .rd_done(rd_done)
    );

    dma_wr_engine u_wr (
        .clk(clk), .rstn(rstn), .start(start),
        .cfg_dest(cfg_dest), .cfg_len(cfg_len),
        .dest_type(dest_type), .dest_size(dest_size),
        .level(level), .pop_data(pop_data),
        .awready(awready), .wready(wready), .bvalid(bvalid),
        .awaddr(awaddr), .awsize(awsize), .awvalid(awvalid),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .bready(bready),
        .pop(pop), .pop_size(pop_size), .wr_done(wr_done)
    );

endmodule

//--- logic/dma_wr_engine.sv
`timescale 1ns/10ps

module dma_wr_engine (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         start,
    input  logic [dma_pkg::ADDR_W-1:0]   cfg_dest,
    input  logic [dma_pkg::ADDR_W-1:0]   cfg_len,
    input  logic [1:0]                   dest_type,
    input  logic [1:0]                   dest_size,
    input  logic [dma_pkg::FIFO_DEPTH_LOG:0] level,
    input  logic [31:0]                  pop_data,
    input  logic                         awready,
    input  logic                         wready,
    input  logic                         bvalid,
    output logic [dma_pkg::ADDR_W-1:0]   awaddr,
    output logic [2:0]                   awsize,
    output logic                         awvalid,
    output logic [31:0]                  wdata,
    output logic [3:0]                   wstrb,
    output logic                         wvalid,
    output logic                         bready,
    output logic                         pop,
    output logic [1:0]                   pop_size,
    output logic                         wr_done
);
    import dma_pkg::*;

    logic [ADDR_W-1:0]       addr;
    logic [ADDR_W-1:0]       cnt;
    logic [ADDR_W-1:0]       step;
    logic [FIFO_DEPTH_LOG:0] need;
    logic [3:0]              strb_base;
    logic                    beat_busy;
    logic                    b_done;

    assign pop_size  = size_m1(dest_size);
    assign step      = ADDR_W'(pop_size) + ADDR_W'(1);
    assign need      = {{(FIFO_DEPTH_LOG-1){1'b0}}, pop_size} +
                       {{FIFO_DEPTH_LOG{1'b0}}, 1'b1};
    assign strb_base = {pop_size[1], pop_size[1], pop_size[0], 1'b1};

    assign awaddr = addr;
    assign awsize = {1'b0, dest_size};
    assign bready = 1'b1;

    // one beat in flight at a time
    assign pop     = |cnt && ~beat_busy && level >= need;
    assign b_done  = bvalid && bready && beat_busy;
    assign wr_done = b_done && ~|cnt;

    // beat moved to its byte lane
    always_ff @(posedge clk) begin
        if (pop) begin
            wdata <= pop_data << {addr[1:0], 3'b0};
            wstrb <= strb_base << addr[1:0];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (~rstn) begin
            addr      <= '0;
            cnt       <= '0;
            beat_busy <= 1'b0;
            awvalid   <= 1'b0;
            wvalid    <= 1'b0;
        end else if (start) begin
            addr      <= cfg_dest;
            cnt       <= cfg_len;
            beat_busy <= 1'b0;
        end else begin
            if (pop) begin
                cnt       <= cnt - step;
                beat_busy <= 1'b1;
                awvalid   <= 1'b1;
                wvalid    <= 1'b1;
            end
            if (awvalid && awready)
                awvalid <= 1'b0;
            if (wvalid && wready)
                wvalid <= 1'b0;
            if (b_done) begin
                beat_busy <= 1'b0;
                if (dest_type == TYPE_INCR)
                    addr <= addr + step;
            end
        end
    end

endmodule

//--- project.f
logic/dma_pkg.sv
logic/dma_regs.sv
logic/dma_byte_fifo.sv
logic/dma_rd_engine.sv
logic/dma_wr_engine.sv
logic/dma_top.sv
verif/dma_props.sv
verif/dma_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the DMA testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module dma_tb \
    -Mdir obj_dir -o Vdma_tb \
    -f project.f

./obj_dir/Vdma_tb 2>&1 | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
    echo "run.sh: simulation reported failure"
    exit 1
fi
echo "run.sh: simulation finished without failure"

//--- verif/dma_props.sv
`timescale 1ns/10ps

module dma_props (
    input logic                       clk,
    input logic                       rstn,
    input logic [dma_pkg::ADDR_W-1:0] araddr,
    input logic                       arvalid,
    input logic                       arready,
    input logic [dma_pkg::ADDR_W-1:0] awaddr,
    input logic                       awvalid,
    input logic                       awready,
    input logic [3:0]                 wstrb,
    input logic                       wvalid,
    input logic                       pready
);

    // read request held until accepted
    ar_hold: assert property (@(posedge clk) disable iff (~rstn)
        arvalid && ~arready |=> arvalid && $stable(araddr))
        else $error("arvalid dropped or araddr moved before arready");

    aw_hold: assert property (@(posedge clk) disable iff (~rstn)
        awvalid && ~awready |=> awvalid && $stable(awaddr))
        else $error("awvalid dropped or awaddr moved before awready");

    // every write beat carries at least one byte
    w_strb: assert property (@(posedge clk) disable iff (~rstn)
        wvalid |-> |wstrb)
        else $error("wvalid high with an empty wstrb");

    apb_ready: assert property (@(posedge clk) disable iff (~rstn) pready)
        else $error("pready went low");

endmodule

bind dma_top dma_props u_props (
    .clk(clk), .rstn(rstn),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wstrb(wstrb), .wvalid(wvalid), .pready(pready)
);

//--- verif/dma_tb.sv
`timescale 1ns/10ps

module dma_tb;
    import dma_pkg::*;

    localparam int N_TESTS = 10;

    typedef struct packed {
        logic [31:0] src;
        logic [31:0] dest;
        logic [31:0] len;
        logic [1:0]  src_type;
        logic [1:0]  dest_type;
        logic [1:0]  src_size;
        logic [1:0]  dest_size;
        logic        legal;
    } test_t;

    logic        clk;
    logic        rstn = 1'b0;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [31:0] araddr;
    logic [2:0]  arsize;
    logic        arvalid;
    logic        arready = 1'b0;
    logic [31:0] rdata = '0;
    logic        rvalid = 1'b0;
    logic        rready;
    logic [31:0] awaddr;
    logic [2:0]  awsize;
    logic        awvalid;
    logic        awready = 1'b0;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready = 1'b0;
    logic        bvalid = 1'b0;
    logic        bready;

    // sparse memory behind the AXI ports
    logic [7:0]  mem [bit [31:0]];
    logic        rd_pend;
    logic [31:0] rd_addr;
    logic        aw_got;
    logic [31:0] aw_addr;
    logic        w_got;
    logic [31:0] w_data;
    logic [3:0]  w_strb;

    logic [31:0] lfsr = 32'h4ca1f91a;
    test_t       tests [N_TESTS];
    string       names [N_TESTS];
    logic [7:0]  exp_q [$];
    int          cur_test = 0;
    int          n_checks = 0;
    int          n_errors = 0;
    int          test_errs = 0;

    dma_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic take_bit();
        lfsr = lfsr_next(lfsr);
        return lfsr[0];
    endfunction

    function automatic logic [7:0] take_byte();
        logic [7:0] b;
        for (int i = 0; i < 8; i++)
            b[i] = take_bit();
        return b;
    endfunction

    function automatic logic [7:0] mem_rd(input logic [31:0] a);
        if (mem.exists(a))
            return mem[a];
        return 8'h00;
    endfunction

    // responses go out on the falling edge and handshakes land on the next rising edge
    always @(negedge clk) begin
        if (~rstn) begin
            arready = 1'b0;
            awready = 1'b0;
            wready  = 1'b0;
            rvalid  = 1'b0;
            bvalid  = 1'b0;
            rd_pend = 1'b0;
            aw_got  = 1'b0;
            w_got   = 1'b0;
        end else begin
            rvalid = 1'b0;
            if (rd_pend && take_bit()) begin
                check_word({names[cur_test], " rready"}, 32'h1, 32'(rready));
                rvalid  = 1'b1;
                rdata   = {mem_rd(rd_addr + 32'd3), mem_rd(rd_addr + 32'd2),
                           mem_rd(rd_addr + 32'd1), mem_rd(rd_addr)};
                rd_pend = 1'b0;
            end
            bvalid = 1'b0;
            if (aw_got && w_got && take_bit()) begin
                check_word({names[cur_test], " bready"}, 32'h1, 32'(bready));
                for (int j = 0; j < 4; j++) begin
                    if (w_strb[j])
                        mem[aw_addr + 32'(j)] = w_data[8*j +: 8];
                end
                bvalid = 1'b1;
                aw_got = 1'b0;
                w_got  = 1'b0;
            end
            arready = take_bit();
            awready = take_bit();
            wready  = take_bit();
            if (arvalid && arready) begin
                check_word({names[cur_test], " arsize"},
                           32'(tests[cur_test].src_size), 32'(arsize));
                rd_pend = 1'b1;
                rd_addr = araddr & ~32'h3;
            end
            if (awvalid && awready) begin
                check_word({names[cur_test], " awsize"},
                           32'(tests[cur_test].dest_size), 32'(awsize));
                aw_got  = 1'b1;
                aw_addr = awaddr & ~32'h3;
            end
            if (wvalid && wready) begin
                w_got  = 1'b1;
                w_data = wdata;
                w_strb = wstrb;
            end
        end
    end

    task automatic add_test(input int i, input string name,
                            input logic [31:0] src, input logic [31:0] dest,
                            input logic [31:0] len, input logic [1:0] st,
                            input logic [1:0] dt, input logic [1:0] ss,
                            input logic [1:0] ds, input logic legal);
        names[i] = name;
        tests[i] = '{src, dest, len, st, dt, ss, ds, legal};
    endtask

    task automatic load_table();
        add_test(0, "incr_word", 32'h1000, 32'h2000, 32, TYPE_INCR, TYPE_INCR,
                 SIZE_WORD, SIZE_WORD, 1'b1);
        add_test(1, "byte_to_word", 32'h1101, 32'h2100, 24, TYPE_INCR, TYPE_INCR,
                 SIZE_BYTE, SIZE_WORD, 1'b1);
        add_test(2, "hword_to_byte", 32'h1202, 32'h2203, 18, TYPE_INCR, TYPE_INCR,
                 SIZE_HWORD, SIZE_BYTE, 1'b1);
        add_test(3, "fixed_src", 32'h1304, 32'h2300, 16, TYPE_FIXED, TYPE_INCR,
                 SIZE_WORD, SIZE_WORD, 1'b1);
        add_test(4, "const_word", 32'ha5c31e77, 32'h2400, 20, TYPE_CONST, TYPE_INCR,
                 SIZE_WORD, SIZE_WORD, 1'b1);
        add_test(5, "const_hword", 32'h5a5a3cc3, 32'h2501, 10, TYPE_CONST, TYPE_INCR,
                 SIZE_HWORD, SIZE_BYTE, 1'b1);
        add_test(6, "fixed_dest", 32'h1500, 32'h2600, 16, TYPE_INCR, TYPE_FIXED,
                 SIZE_HWORD, SIZE_WORD, 1'b1);
        add_test(7, "len_zero", 32'h1600, 32'h2700, 0, TYPE_INCR, TYPE_INCR,
                 SIZE_WORD, SIZE_WORD, 1'b0);
        add_test(8, "rsvd_type", 32'h1700, 32'h2800, 8, TYPE_RSVD, TYPE_INCR,
                 SIZE_WORD, SIZE_WORD, 1'b0);
        add_test(9, "misaligned", 32'h1802, 32'h2900, 8, TYPE_INCR, TYPE_INCR,
                 SIZE_WORD, SIZE_WORD, 1'b0);
    endtask

    function automatic int cycle_limit();
        int sum;
        sum = 200;
        for (int i = 0; i < N_TESTS; i++)
            sum += 40 * int'(tests[i].len);
        return sum;
    endfunction

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = {24'h0, addr};
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        check_word({names[cur_test], " pslverr"}, 32'h0, 32'(pslverr));
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = {24'h0, addr};
        @(negedge clk);
        penable = 1'b1;
        data    = prdata;
        check_word({names[cur_test], " pslverr"}, 32'h0, 32'(pslverr));
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_word(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            test_errs++;
            $display("mismatch %s: expected %h actual %h", what, exp, act);
        end
    endtask

    task automatic check_con(input string what, input dma_con_u exp, input dma_con_u act);
        n_checks++;
        if (act.w !== exp.w) begin
            n_errors++;
            test_errs++;
            $display("mismatch %s: expected %h actual %h", what, exp.w, act.w);
        end
    endtask

    // byte k of the source stream as the FIFO sees it
    function automatic logic [7:0] stream_byte(input test_t t, input int k);
        int s;
        s = 1 << t.src_size;
        case (t.src_type)
            TYPE_INCR:  return mem_rd(t.src + 32'(k));
            TYPE_FIXED: return mem_rd(t.src + 32'(k % s));
            default:    return t.src[8*(k % s) +: 8];
        endcase
    endfunction

    task automatic fill_memory(input test_t t);
        if (t.src_type != TYPE_CONST) begin
            for (int i = 0; i < int'(t.len); i++)
                mem[t.src + 32'(i)] = take_byte();
        end
        for (int i = 0; i < int'(t.len) + 16; i++)
            mem[t.dest - 32'd4 + 32'(i)] = take_byte();
    endtask

    // destination window with four guard bytes on each side
    task automatic build_expect(input test_t t);
        int d;
        int w;
        int off;
        d = 1 << t.dest_size;
        if (!t.legal)
            w = 8;
        else if (t.dest_type == TYPE_INCR)
            w = int'(t.len);
        else
            w = d;
        exp_q.delete();
        for (int i = 0; i < w + 8; i++) begin
            off = i - 4;
            if (t.legal && off >= 0 && off < w) begin
                if (t.dest_type == TYPE_INCR)
                    exp_q.push_back(stream_byte(t, off));
                else
                    exp_q.push_back(stream_byte(t, int'(t.len) - d + off));
            end else begin
                exp_q.push_back(mem_rd(t.dest - 32'd4 + 32'(i)));
            end
        end
    endtask

    initial begin
        test_t       t;
        dma_con_u    con;
        dma_con_u    exp_con;
        logic [31:0] rd;
        load_table();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        rstn    = 1'b0;
        repeat (3) @(negedge clk);
        rstn = 1'b1;
        for (int i = 0; i < N_TESTS; i++) begin
            t = tests[i];
            cur_test = i;
            test_errs = 0;
            @(posedge clk);
            fill_memory(t);
            build_expect(t);
            apb_write(REG_SRC, t.src);
            apb_write(REG_DEST, t.dest);
            apb_write(REG_LEN, t.len);
            apb_read(REG_SRC, rd);
            check_word({names[i], " src"}, t.src, rd);
            apb_read(REG_DEST, rd);
            check_word({names[i], " dest"}, t.dest, rd);
            apb_read(REG_LEN, rd);
            check_word({names[i], " len"}, t.len, rd);
            con.w           = '0;
            con.f.en        = 1'b1;
            con.f.src_type  = t.src_type;
            con.f.dest_type = t.dest_type;
            con.f.src_size  = t.src_size;
            con.f.dest_size = t.dest_size;
            apb_write(REG_CON, con.w);
            exp_con        = con;
            exp_con.f.en   = 1'b0;
            exp_con.f.busy = t.legal;
            apb_read(REG_CON, rd);
            con.w = rd;
            check_con({names[i], " control"}, exp_con, con);
            while (con.f.busy) begin
                apb_read(REG_CON, rd);
                con.w = rd;
            end
            @(posedge clk);
            for (int j = 0; j < exp_q.size(); j++)
                check_word($sformatf("%s byte %0d", names[i], j - 4), {24'h0, exp_q[j]},
                           {24'h0, mem_rd(t.dest - 32'd4 + 32'(j))});
            $display("test %s: %0d errors", names[i], test_errs);
        end
        $display("done: %0d tests, %0d checks, %0d errors", N_TESTS, n_checks, n_errors);
        if (n_errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    initial begin
        int limit;
        int cycles;
        cycles = 0;
        @(posedge rstn);
        limit = cycle_limit();
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: transfers still running after %0d cycles", limit);
        $display("Simulation FAILED");
        $finish;
    end

endmodule
